// ==== synth_params.f ====
source/synth_pkg.sv
source/param_bank.sv
source/param_arbiter.sv
source/sysex_decoder.sv
source/synth_params.sv
bench/tb_synth_params.sv

// ==== bench/tb_synth_params.sv ====
/* testbench for the synth parameter subsystem
   directed cpu and sysex tests against a byte model of the five banks */

module tb_synth_params import synth_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TESTS = 6;   // watchdog budget is per test

    logic              reg_clk = 1'b0;
    logic              rst;
    logic              chipselect;
    logic              cpu_read;
    logic              cpu_write;
    logic [ADDR_W-1:0] address;
    logic [7:0]        cpu_wdata;
    logic [7:0]        cpu_rdata;
    logic [7:0]        midi_in_byte;
    logic              midi_in_valid;
    logic [7:0]        midi_out_byte;
    logic              midi_out_valid;

    logic [7:0]  model [5][128];        // expected bank contents as read back
    logic [31:0] lcg_state = 32'hf0037e27;

    synth_params #(.DEPTH(128)) UUT (
        .reg_clk        (reg_clk),
        .rst            (rst),
        .chipselect     (chipselect),
        .cpu_read       (cpu_read),
        .cpu_write      (cpu_write),
        .address        (address),
        .cpu_wdata      (cpu_wdata),
        .cpu_rdata      (cpu_rdata),
        .midi_in_byte   (midi_in_byte),
        .midi_in_valid  (midi_in_valid),
        .midi_out_byte  (midi_out_byte),
        .midi_out_valid (midi_out_valid)
    );

    always #10 reg_clk = ~reg_clk;  // 20 ns period

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        abort_run();
    endtask

    task automatic next_cycle();
        @(posedge reg_clk);
        #2;                         // inputs move just after the edge
    endtask

    // envelope keeps 7 bits so the top bit reads back as 0
    task automatic model_write(input logic [2:0] bank, input logic [6:0] entry,
                               input logic [7:0] data);
        if (bank == ENV)
            model[bank][entry] = {1'b0, data[6:0]};
        else if (bank < 5)
            model[bank][entry] = data;
    endtask

    function automatic logic [7:0] expect_byte(input logic [2:0] bank, input logic [6:0] entry);
        if (bank < 5)
            return model[bank][entry];
        return 8'h00;               // unmapped codes 5..7
    endfunction

    function automatic logic [55:0] write_msg(input logic [2:0] bank, input logic [6:0] entry,
                                              input logic [7:0] data);
        return {8'hF0, 8'h7D, 8'h01, 5'b0, bank, 1'b0, entry, data, 8'hF7};
    endfunction

    function automatic logic [55:0] read_msg(input logic [2:0] bank, input logic [6:0] entry);
        return {8'h00, 8'hF0, 8'h7D, 8'h02, 5'b0, bank, 1'b0, entry, 8'hF7};
    endfunction

    task automatic cpu_wr(input logic [2:0] bank, input logic [6:0] entry,
                          input logic [7:0] data);
        chipselect = 1'b1;
        cpu_write  = 1'b1;
        address    = {bank, entry};
        cpu_wdata  = data;
        next_cycle();
        chipselect = 1'b0;
        cpu_write  = 1'b0;
        model_write(bank, entry, data);
        next_cycle();               // memory written on this edge
    endtask

    task automatic cpu_rd_check(input logic [2:0] bank, input logic [6:0] entry);
        logic [7:0] exp;
        exp        = expect_byte(bank, entry);
        chipselect = 1'b1;
        cpu_read   = 1'b1;
        address    = {bank, entry};
        next_cycle();
        chipselect = 1'b0;
        cpu_read   = 1'b0;
        next_cycle();               // data two edges after the strobe
        assert (cpu_rdata === exp)
        else report_error($sformatf("cpu read bank %0d entry %02h got %02h expected %02h",
                                    bank, entry, cpu_rdata, exp));
    endtask

    // n bytes with the first byte in the highest used lane
    task automatic send_midi(input logic [55:0] msg, input int n);
        for (int i = 0; i < n; i++) begin
            midi_in_byte  = msg[8*(n-1-i) +: 8];
            midi_in_valid = 1'b1;
            next_cycle();
        end
        midi_in_valid = 1'b0;
    endtask

    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            assert (!midi_out_valid)
            else report_error($sformatf("unexpected reply byte %02h", midi_out_byte));
            next_cycle();
        end
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////
    task automatic test_reset_state();
        assert (!midi_out_valid) else report_error("midi_out_valid high after reset");
        assert (cpu_rdata === 8'h00)
        else report_error($sformatf("cpu_rdata %02h after reset, expected 00", cpu_rdata));
    endtask

    task automatic test_cpu_access();
        logic [2:0]  t_bank  [24];
        logic [6:0]  t_entry [24];
        logic [31:0] r;
        for (int i = 0; i < 24; i++) begin  // three per code including unmapped
            r          = next_random();
            t_bank[i]  = 3'(i / 3);
            t_entry[i] = r[14:8];
            cpu_wr(t_bank[i], t_entry[i], r[7:0]);
        end
        for (int i = 0; i < 24; i++)
            cpu_rd_check(t_bank[i], t_entry[i]);
    endtask

    task automatic test_sysex_write();
        cpu_wr(ENV, 7'h41, 8'h00);
        send_midi(write_msg(ENV, 7'h41, 8'hC5), 7);   // top bit drops in env
        model_write(ENV, 7'h41, 8'hC5);
        repeat (10) next_cycle();
        cpu_rd_check(ENV, 7'h41);
    endtask

    task automatic test_sysex_read();
        logic [55:0] exp;
        int          waited;
        cpu_wr(OSC, 7'h22, 8'h9C);  // negative value must come back unchanged
        exp    = {8'hF0, 8'h7D, 8'h03, 8'h01, 8'h22, 8'h9C, 8'hF7};
        waited = 0;
        send_midi(read_msg(OSC, 7'h22), 6);
        while (!midi_out_valid && waited < 40) begin
            next_cycle();
            waited++;
        end
        assert (midi_out_valid)
        else begin
            $display("no sysex reply seen within 40 cycles of the read message");
            abort_run();
        end
        for (int i = 0; i < 7; i++) begin   // back to back at one per cycle
            assert (midi_out_valid && midi_out_byte === exp[8*(6-i) +: 8])
            else report_error($sformatf("reply byte %0d got %02h valid %b expected %02h",
                                        i, midi_out_byte, midi_out_valid, exp[8*(6-i) +: 8]));
            next_cycle();
        end
        assert (!midi_out_valid) else report_error("reply longer than seven bytes");
    endtask

    task automatic test_arbitration();
        logic [31:0] rnd;
        for (int k = 0; k < 5; k++) begin
            rnd = next_random();
            cpu_wr(3'(k), 7'(8'h60 + k), rnd[31:24]);
        end
        cpu_wr(MOD2, 7'h10, 8'hA5);
        fork
            send_midi(write_msg(MOD2, 7'h10, 8'h5A), 7);
            begin
                next_cycle();   // request rises in a cycle with a cpu strobe
                for (int r = 0; r < 12; r++)    // read every other cycle
                    cpu_rd_check(3'(r % 5), 7'(8'h60 + r % 5));
            end
        join
        model_write(MOD2, 7'h10, 8'h5A);
        cpu_rd_check(MOD2, 7'h10);  // granted in a gap between reads
    endtask

    task automatic test_malformed();
        cpu_wr(COM, 7'h05, 8'h33);
        send_midi({8'hF0, 8'h7C, 8'h01, 8'h04, 8'h05, 8'hAA, 8'hF7}, 7);    // wrong id
        check_quiet(12);
        send_midi({8'h00, 8'hF0, 8'h7D, 8'h05, 8'h04, 8'h05, 8'hF7}, 6);    // bad command
        check_quiet(12);
        cpu_rd_check(COM, 7'h05);
    endtask

    ////////////////////////////////////////
    // run
    ////////////////////////////////////////
    initial begin
        rst           = 1'b1;
        chipselect    = 1'b0;
        cpu_read      = 1'b0;
        cpu_write     = 1'b0;
        address       = '0;
        cpu_wdata     = 8'h00;
        midi_in_byte  = 8'h00;
        midi_in_valid = 1'b0;
        repeat (4) @(posedge reg_clk);
        #2 rst = 1'b0;
        test_reset_state();
        test_cpu_access();
        test_sysex_write();
        test_sysex_read();
        test_arbitration();
        test_malformed();
        $display("PASS: all tests");
        $finish;
    end

    initial begin
        #(NUM_TESTS * 2000);
        $display("timeout: tests still running at %0t", $time);
        abort_run();
    end

endmodule

// ==== source/synth_params.sv ====
/* synth parameter register subsystem
   cpu port and sysex decoder share one bus into five parameter banks */

module synth_params import synth_pkg::*; #(
    parameter int DEPTH = 128
) (
    input  logic              reg_clk,
    input  logic              rst,
    // cpu bus
    input  logic              chipselect,
    input  logic              cpu_read,
    input  logic              cpu_write,
    input  logic [ADDR_W-1:0] address,
    input  logic [7:0]        cpu_wdata,
    output logic [7:0]        cpu_rdata,
    // midi bytes
    input  logic [7:0]        midi_in_byte,
    input  logic              midi_in_valid,
    output logic [7:0]        midi_out_byte,
    output logic              midi_out_valid
);

    // sysex master
    logic                      syx_req;
    logic                      syx_we;
    bank_t                     syx_bank;
    logic [ENTRY_W-1:0]        syx_entry;
    logic [7:0]                syx_wdata;
    logic                      syx_grant;
    logic                      syx_rvalid;
    logic [7:0]                bus_rdata;
    // bank bus
    logic [NUM_BANKS-1:0]      bank_sel;
    logic                      bus_we;
    logic [ENTRY_W-1:0]        bus_entry;
    logic [7:0]                bus_wdata;
    logic [NUM_BANKS-1:0][7:0] bank_rdata;

    sysex_decoder sysex_decoder_inst (
        .reg_clk        (reg_clk),
        .rst            (rst),
        .midi_in_byte   (midi_in_byte),
        .midi_in_valid  (midi_in_valid),
        .syx_grant      (syx_grant),
        .syx_rvalid     (syx_rvalid),
        .bus_rdata      (bus_rdata),
        .syx_req        (syx_req),
        .syx_we         (syx_we),
        .syx_bank       (syx_bank),
        .syx_entry      (syx_entry),
        .syx_wdata      (syx_wdata),
        .midi_out_byte  (midi_out_byte),
        .midi_out_valid (midi_out_valid)
    );

    param_arbiter #(.DEPTH(DEPTH)) param_arbiter_inst (
        .reg_clk    (reg_clk),
        .rst        (rst),
        .chipselect (chipselect),
        .cpu_read   (cpu_read),
        .cpu_write  (cpu_write),
        .address    (address),
        .cpu_wdata  (cpu_wdata),
        .syx_req    (syx_req),
        .syx_we     (syx_we),
        .syx_bank   (syx_bank),
        .syx_entry  (syx_entry),
        .syx_wdata  (syx_wdata),
        .bank_rdata (bank_rdata),
        .syx_grant  (syx_grant),
        .syx_rvalid (syx_rvalid),
        .bus_rdata  (bus_rdata),
        .cpu_rdata  (cpu_rdata),
        .bank_sel   (bank_sel),
        .bus_we     (bus_we),
        .bus_entry  (bus_entry),
        .bus_wdata  (bus_wdata)
    );

    ////////////////////////////////////////
    // banks, one per bank code
    ////////////////////////////////////////
    param_bank #(.DEPTH(DEPTH), .payload_t(env_rate_t)) env_bank (
        .reg_clk(reg_clk), .sel(bank_sel[ENV]), .we(bus_we),
        .entry(bus_entry), .wdata(bus_wdata), .rdata(bank_rdata[ENV])
    );

    param_bank #(.DEPTH(DEPTH), .payload_t(osc_param_t)) osc_bank (
        .reg_clk(reg_clk), .sel(bank_sel[OSC]), .we(bus_we),
        .entry(bus_entry), .wdata(bus_wdata), .rdata(bank_rdata[OSC])
    );

    param_bank #(.DEPTH(DEPTH), .payload_t(osc_param_t)) mod1_bank (  // mod uses osc format
        .reg_clk(reg_clk), .sel(bank_sel[MOD1]), .we(bus_we),
        .entry(bus_entry), .wdata(bus_wdata), .rdata(bank_rdata[MOD1])
    );

    param_bank #(.DEPTH(DEPTH), .payload_t(osc_param_t)) mod2_bank (
        .reg_clk(reg_clk), .sel(bank_sel[MOD2]), .we(bus_we),
        .entry(bus_entry), .wdata(bus_wdata), .rdata(bank_rdata[MOD2])
    );

    param_bank #(.DEPTH(DEPTH), .payload_t(com_param_t)) com_bank (
        .reg_clk(reg_clk), .sel(bank_sel[COM]), .we(bus_we),
        .entry(bus_entry), .wdata(bus_wdata), .rdata(bank_rdata[COM])
    );

endmodule

// ==== source/sysex_decoder.sv ====
/* sysex command decoder
   turns write/read messages into parameter bus requests, sends read replies */

module sysex_decoder import synth_pkg::*; (
    input  logic               reg_clk,
    input  logic               rst,
    input  logic [7:0]         midi_in_byte,
    input  logic               midi_in_valid,
    input  logic               syx_grant,
    input  logic               syx_rvalid,
    input  logic [7:0]         bus_rdata,
    output logic               syx_req,
    output logic               syx_we,
    output bank_t              syx_bank,
    output logic [ENTRY_W-1:0] syx_entry,
    output logic [7:0]         syx_wdata,
    output logic [7:0]         midi_out_byte,
    output logic               midi_out_valid
);

    typedef enum logic [2:0] {P_IDLE, P_ID, P_CMD, P_BANK, P_ENTRY, P_DATA, P_END} parse_t;

    parse_t             pstate;
    logic               cap_we;     // fields of the message being parsed
    bank_t              cap_bank;
    logic [ENTRY_W-1:0] cap_entry;
    logic [7:0]         cap_data;
    logic               pend;       // complete message waiting for the bus
    logic               pend_we;
    bank_t              pend_bank;
    logic [ENTRY_W-1:0] pend_entry;
    logic [7:0]         pend_data;
    logic               rd_wait;    // read granted, data not back yet
    logic               rply_busy;
    logic [2:0]         rply_step;
    logic [7:0]         rply_data;
    logic               msg_done;
    logic               launch_ok;

    assign msg_done  = midi_in_valid && (pstate == P_END) && (midi_in_byte == SYX_END);
    assign launch_ok = !syx_req && !rd_wait && !rply_busy;

    ////////////////////////////////////////
    // message parser
    ////////////////////////////////////////
    always_ff @(posedge reg_clk) begin
        if (rst) begin
            pstate <= P_IDLE;
        end else if (midi_in_valid) begin
            if (midi_in_byte == SYX_START) begin
                pstate <= P_ID; // F0 always restarts
            end else begin
                case (pstate)
                    P_ID:    pstate <= (midi_in_byte == SYX_ID) ? P_CMD : P_IDLE;
                    P_CMD: begin
                        cap_we <= (midi_in_byte == SYX_CMD_WRITE);
                        if (midi_in_byte == SYX_CMD_WRITE || midi_in_byte == SYX_CMD_READ)
                            pstate <= P_BANK;
                        else
                            pstate <= P_IDLE;   // unknown command
                    end
                    P_BANK: begin
                        cap_bank <= bank_t'(midi_in_byte[BANK_W-1:0]);
                        pstate   <= P_ENTRY;
                    end
                    P_ENTRY: begin
                        cap_entry <= midi_in_byte[ENTRY_W-1:0];
                        pstate    <= cap_we ? P_DATA : P_END;
                    end
                    P_DATA: begin
                        cap_data <= midi_in_byte;
                        pstate   <= P_END;
                    end
                    default: pstate <= P_IDLE; // P_END handled by msg_done, junk waits for F0
                endcase
            end
        end
    end

    ////////////////////////////////////////
    // bus request
    ////////////////////////////////////////
    always_ff @(posedge reg_clk) begin
        if (rst) begin
            pend    <= 1'b0;
            syx_req <= 1'b0;
            rd_wait <= 1'b0;
        end else begin
            if (msg_done) begin         // park it, newest message wins
                pend       <= 1'b1;
                pend_we    <= cap_we;
                pend_bank  <= cap_bank;
                pend_entry <= cap_entry;
                pend_data  <= cap_data;
            end
            if ((pend || msg_done) && launch_ok) begin
                syx_req   <= 1'b1;
                syx_we    <= msg_done ? cap_we    : pend_we;
                syx_bank  <= msg_done ? cap_bank  : pend_bank;
                syx_entry <= msg_done ? cap_entry : pend_entry;
                syx_wdata <= msg_done ? cap_data  : pend_data;
                pend      <= 1'b0;
            end
            if (syx_grant) begin
                syx_req <= 1'b0;
                rd_wait <= !syx_we;     // reads wait for rvalid
            end else if (syx_rvalid) begin
                rd_wait <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // reply F0 7D 03 bank entry data F7
    ////////////////////////////////////////
    always_ff @(posedge reg_clk) begin
        if (rst) begin
            rply_busy      <= 1'b0;
            midi_out_valid <= 1'b0;
        end else begin
            midi_out_valid <= 1'b0;
            if (syx_rvalid) begin
                rply_data      <= bus_rdata;
                rply_step      <= 3'd1;
                rply_busy      <= 1'b1;
                midi_out_byte  <= SYX_START;
                midi_out_valid <= 1'b1;
            end else if (rply_busy) begin
                midi_out_valid <= 1'b1;
                rply_step      <= rply_step + 3'd1;
                case (rply_step)
                    3'd1:    midi_out_byte <= SYX_ID;
                    3'd2:    midi_out_byte <= SYX_CMD_REPLY;
                    3'd3:    midi_out_byte <= {5'b0, syx_bank};
                    3'd4:    midi_out_byte <= {1'b0, syx_entry};
                    3'd5:    midi_out_byte <= rply_data;
                    default: midi_out_byte <= SYX_END;
                endcase
                if (rply_step == 3'd6)
                    rply_busy <= 1'b0; // last byte out
            end
        end
    end

endmodule

// ==== source/param_arbiter.sv ====
/* parameter bus arbiter, cpu over sysex
   registers address, decodes bank selects, routes read bytes back */

module param_arbiter import synth_pkg::*; #(
    parameter int DEPTH = 128
) (
    input  logic                      reg_clk,
    input  logic                      rst,
    input  logic                      chipselect,
    input  logic                      cpu_read,
    input  logic                      cpu_write,
    input  logic [ADDR_W-1:0]         address,
    input  logic [7:0]                cpu_wdata,
    input  logic                      syx_req,
    input  logic                      syx_we,
    input  bank_t                     syx_bank,
    input  logic [ENTRY_W-1:0]        syx_entry,
    input  logic [7:0]                syx_wdata,
    input  logic [NUM_BANKS-1:0][7:0] bank_rdata,
    output logic                      syx_grant,
    output logic                      syx_rvalid,
    output logic [7:0]                bus_rdata,
    output logic [7:0]                cpu_rdata,
    output logic [NUM_BANKS-1:0]      bank_sel,
    output logic                      bus_we,
    output logic [ENTRY_W-1:0]        bus_entry,
    output logic [7:0]                bus_wdata
);

    // entries above DEPTH alias
    localparam logic [ENTRY_W-1:0] ENTRY_MASK = ENTRY_W'(DEPTH - 1);

    logic              cpu_strobe;
    logic [BANK_W-1:0] bus_code;    // stage 1 tag
    logic              rd1_v;
    logic              rd1_syx;
    logic [BANK_W-1:0] cpu_code;    // stage 2 tags
    logic [BANK_W-1:0] syx_code;

    function automatic logic [NUM_BANKS-1:0] bank_onehot(input logic [BANK_W-1:0] code);
        logic [NUM_BANKS-1:0] sel;
        sel = '0;
        if (code < NUM_BANKS)
            sel[code] = 1'b1;       // 5..7 select nothing
        return sel;
    endfunction

    function automatic logic [7:0] pick_byte(input logic [BANK_W-1:0] code,
                                             input logic [NUM_BANKS-1:0][7:0] rd);
        logic [7:0] b;
        b = 8'h00;                  // unmapped reads 00
        if (code < NUM_BANKS)
            b = rd[code];
        return b;
    endfunction

    assign cpu_strobe = chipselect && (cpu_read || cpu_write);
    assign syx_grant  = syx_req && !cpu_strobe; // idle cycle only, never stalls cpu

    ////////////////////////////////////////
    // address stage + read tag pipeline
    ////////////////////////////////////////
    always_ff @(posedge reg_clk) begin
        if (rst) begin
            bank_sel   <= '0;
            bus_we     <= 1'b0;
            rd1_v      <= 1'b0;
            rd1_syx    <= 1'b0;
            syx_rvalid <= 1'b0;
            cpu_code   <= '1;           // unmapped, cpu_rdata reads 00
        end else begin
            bank_sel <= '0;
            bus_we   <= 1'b0;
            rd1_v    <= 1'b0;
            if (cpu_strobe) begin
                bus_code  <= address[ADDR_W-1:ENTRY_W];
                bank_sel  <= bank_onehot(address[ADDR_W-1:ENTRY_W]);
                bus_we    <= cpu_write;
                bus_entry <= address[ENTRY_W-1:0] & ENTRY_MASK;
                bus_wdata <= cpu_wdata;
                rd1_v     <= cpu_read;
                rd1_syx   <= 1'b0;
            end else if (syx_grant) begin
                bus_code  <= syx_bank;
                bank_sel  <= bank_onehot(syx_bank);
                bus_we    <= syx_we;
                bus_entry <= syx_entry & ENTRY_MASK;
                bus_wdata <= syx_wdata;
                rd1_v     <= !syx_we;
                rd1_syx   <= 1'b1;
            end
            // stage 2, bank bytes land on this edge
            syx_rvalid <= rd1_v && rd1_syx;
            if (rd1_v && !rd1_syx)
                cpu_code <= bus_code;
            if (rd1_v && rd1_syx)
                syx_code <= bus_code;
        end
    end

    // bank bytes are registered and held, steer them by tag
    assign cpu_rdata = pick_byte(cpu_code, bank_rdata);
    assign bus_rdata = pick_byte(syx_code, bank_rdata);

endmodule

// ==== source/param_bank.sv ====
/* one parameter bank
   DEPTH entries of payload_t, byte wide write and registered read-back */

module param_bank import synth_pkg::*; #(
    parameter int  DEPTH     = 128,
    parameter type payload_t = logic [7:0]
) (
    input  logic               reg_clk,
    input  logic               sel,
    input  logic               we,
    input  logic [ENTRY_W-1:0] entry,
    input  logic [7:0]         wdata,
    output logic [7:0]         rdata
);

    localparam int AW = $clog2(DEPTH);      // index bits actually used
    localparam int PW = $bits(payload_t);   // stored width, 7 or 8

    payload_t         mem [DEPTH];
    logic [AW-1:0]    idx;

    assign idx = entry[AW-1:0]; // upper entry bits alias

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////
    always_ff @(posedge reg_clk) begin
        if (sel && we)
            mem[idx] <= payload_t'(wdata[PW-1:0]);  // drop bits above payload
    end

    // read-back, held until the next selected read
    always_ff @(posedge reg_clk) begin
        if (sel && !we)
            rdata <= 8'(unsigned'(mem[idx]));       // zero extend narrow payloads
    end

endmodule

// ==== source/synth_pkg.sv ====
/* parameter subsystem shared definitions
   bank codes, payload types, sysex bytes and bus widths */

package synth_pkg;

    ////////////////////////////////////////
    // bus widths
    ////////////////////////////////////////
    localparam int ADDR_W    = 10;               // cpu address, bank bits over entry bits
    localparam int ENTRY_W   = 7;                // entry address inside a bank
    localparam int BANK_W    = ADDR_W - ENTRY_W; // bank code bits
    localparam int NUM_BANKS = 5;

    // bank codes, 5..7 unmapped
    typedef enum logic [BANK_W-1:0] {
        ENV  = 3'd0,
        OSC  = 3'd1,
        MOD1 = 3'd2,
        MOD2 = 3'd3,
        COM  = 3'd4
    } bank_t;

    ////////////////////////////////////////
    // stored payloads
    ////////////////////////////////////////
    typedef logic [6:0]        env_rate_t;  // envelope rate, 7 bit
    typedef logic signed [7:0] osc_param_t; // osc and mod values
    typedef logic [7:0]        com_param_t; // common values

    // sysex framing
    localparam logic [7:0] SYX_START     = 8'hF0;
    localparam logic [7:0] SYX_END       = 8'hF7;
    localparam logic [7:0] SYX_ID        = 8'h7D; // non-commercial id
    localparam logic [7:0] SYX_CMD_WRITE = 8'h01;
    localparam logic [7:0] SYX_CMD_READ  = 8'h02;
    localparam logic [7:0] SYX_CMD_REPLY = 8'h03;

endpackage
